// ==== hdl/net_pkg.sv ====
package net_pkg;

    // rmii_rx frame states
    typedef enum logic [1:0] {
        rx_idle,
        rx_preamble,
        rx_data
    } rx_state_t;

    // mac_filter states
    typedef enum logic [1:0] {
        filt_header,
        filt_payload,
        filt_drop
    } filt_state_t;

    typedef logic [47:0] mac_addr_t;

    localparam mac_addr_t broadcast_mac = 48'hffff_ffff_ffff;
    localparam int header_bytes = 14; // dst + src + ethertype

    // 0x55 and 0xd5 seen on the wire, low dibit first
    localparam logic [1:0] preamble_dibit = 2'b01;
    localparam logic [1:0] sfd_dibit = 2'b11;

    // reflected crc-32
    localparam logic [31:0] crc_poly = 32'hedb8_8320;
    localparam logic [31:0] crc_residue = 32'hdebb_20e3; // register after a good fcs

endpackage

// ==== hdl/status_pkg.sv ====
package status_pkg;

    typedef logic [3:0] digit_t;
    typedef logic [2:0] scan_pos_t; // which of the eight digits is lit

    // segments {g,f,e,d,c,b,a}, active low
    function automatic logic [6:0] seg_table(input digit_t d);
        case (d)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'ha: return 7'b0001000;
            4'hb: return 7'b0000011;
            4'hc: return 7'b1000110;
            4'hd: return 7'b0100001;
            4'he: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

endpackage

// ==== hdl/rmii_rx.sv ====
`timescale 1ns/1ps

module rmii_rx (
    input  logic       clk_50mhz,
    input  logic       rst,
    input  logic       crsdv,
    input  logic [1:0] rxd,
    output logic       rx_valid,
    output logic [1:0] rx_data,
    output logic       rx_end
);

    net_pkg::rx_state_t state;

    // dibit pipeline, valid qualifies it
    always_ff @(posedge clk_50mhz) begin
        rx_data <= rxd;
    end

    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            state    <= net_pkg::rx_idle;
            rx_valid <= 1'b0;
            rx_end   <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            rx_end   <= 1'b0;
            case (state)
                net_pkg::rx_idle: begin
                    if (crsdv && rxd == net_pkg::preamble_dibit) begin
                        state <= net_pkg::rx_preamble;
                    end
                end
                net_pkg::rx_preamble: begin
                    if (!crsdv) begin
                        state <= net_pkg::rx_idle;
                    end else if (rxd == net_pkg::sfd_dibit) begin
                        state <= net_pkg::rx_data; // delimiter done
                    end else if (rxd != net_pkg::preamble_dibit) begin
                        state <= net_pkg::rx_idle; // not a preamble after all
                    end
                end
                net_pkg::rx_data: begin
                    if (crsdv) begin
                        rx_valid <= 1'b1;
                    end else begin
                        // carrier gone, frame finished
                        state  <= net_pkg::rx_idle;
                        rx_end <= 1'b1;
                    end
                end
                default: begin
                    state <= net_pkg::rx_idle;
                end
            endcase
        end
    end

endmodule

// ==== hdl/bit_order.sv ====
`timescale 1ns/1ps

module bit_order (
    input  logic       clk_50mhz,
    input  logic       rst,
    input  logic       rx_valid,
    input  logic [1:0] rx_data,
    output logic       bo_valid,
    output logic [1:0] bo_data
);

    logic [7:0] byte_buf [2]; // ping-pong pair
    logic       fill_sel;
    logic [1:0] in_cnt;
    logic       playing;
    logic       play_sel;
    logic [1:0] play_cnt;

    always_ff @(posedge clk_50mhz) begin
        if (rx_valid) begin
            byte_buf[fill_sel][{in_cnt, 1'b0} +: 2] <= rx_data; // line order, low dibit first
        end
        if (playing) begin
            bo_data <= byte_buf[play_sel][{~play_cnt, 1'b0} +: 2]; // high dibit first
        end
    end

    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            fill_sel <= 1'b0;
            in_cnt   <= 2'd0;
            playing  <= 1'b0;
            play_sel <= 1'b0;
            play_cnt <= 2'd0;
            bo_valid <= 1'b0;
        end else begin
            bo_valid <= playing;
            if (playing) begin
                play_cnt <= play_cnt + 2'd1;
                if (play_cnt == 2'd3) begin
                    playing <= 1'b0;
                end
            end
            if (!rx_valid) begin
                in_cnt <= 2'd0; // realign between frames
            end else begin
                in_cnt <= in_cnt + 2'd1;
                if (in_cnt == 2'd3) begin
                    // byte complete, replay it while the other buffer fills
                    fill_sel <= ~fill_sel;
                    playing  <= 1'b1;
                    play_sel <= fill_sel;
                    play_cnt <= 2'd0;
                end
            end
        end
    end

endmodule

// ==== hdl/mac_filter.sv ====
`timescale 1ns/1ps

module mac_filter #(
    parameter net_pkg::mac_addr_t local_mac = 48'h02_00_00_00_00_01
) (
    input  logic       clk_50mhz,
    input  logic       rst,
    input  logic       bo_valid,
    input  logic [1:0] bo_data,
    input  logic       rx_end,
    output logic       fw_valid,
    output logic [1:0] fw_data,
    output logic       accepted
);

    localparam logic [5:0] dest_last = 6'd23; // last dibit of byte six
    localparam logic [5:0] hdr_last  = 6'(net_pkg::header_bytes * 4 - 1);

    net_pkg::filt_state_t state;
    net_pkg::mac_addr_t   dest;
    net_pkg::mac_addr_t   dest_next;
    logic [5:0]           hdr_cnt;
    logic                 end_pending;
    logic                 addr_hit;

    assign dest_next = {dest[45:0], bo_data};
    assign addr_hit  = (dest_next == local_mac) || (dest_next == net_pkg::broadcast_mac);

    always_ff @(posedge clk_50mhz) begin
        if (bo_valid && state == net_pkg::filt_header && hdr_cnt <= dest_last) begin
            dest <= dest_next;
        end
        fw_data <= bo_data;
    end

    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            state       <= net_pkg::filt_header;
            hdr_cnt     <= 6'd0;
            end_pending <= 1'b0;
            accepted    <= 1'b0;
            fw_valid    <= 1'b0;
        end else begin
            fw_valid <= 1'b0;
            if (end_pending && !bo_valid) begin
                // reordered tail has drained, rearm for the next header
                state       <= net_pkg::filt_header;
                hdr_cnt     <= 6'd0;
                end_pending <= 1'b0;
            end else if (bo_valid) begin
                case (state)
                    net_pkg::filt_header: begin
                        hdr_cnt <= hdr_cnt + 6'd1;
                        if (hdr_cnt == 6'd0) begin
                            accepted <= 1'b0; // previous verdict expires here
                        end
                        if (hdr_cnt == dest_last) begin
                            if (addr_hit) begin
                                accepted <= 1'b1;
                            end else begin
                                state <= net_pkg::filt_drop;
                            end
                        end
                        if (hdr_cnt == hdr_last) begin
                            state <= net_pkg::filt_payload;
                        end
                    end
                    net_pkg::filt_payload: begin
                        fw_valid <= 1'b1;
                    end
                    default: ; // drop, swallow the rest
                endcase
            end
            if (rx_end) begin
                end_pending <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/word_pack.sv ====
`timescale 1ns/1ps

module word_pack (
    input  logic        clk_50mhz,
    input  logic        rst,
    input  logic        fw_valid,
    input  logic [1:0]  fw_data,
    input  logic        rx_end,
    output logic        word_valid,
    output logic [31:0] word
);

    logic [31:0] word_sr;
    logic [3:0]  cnt; // dibits in current word
    logic        end_pending;

    assign word = word_sr; // stable for the cycle word_valid is high

    always_ff @(posedge clk_50mhz) begin
        if (fw_valid) begin
            word_sr <= {word_sr[29:0], fw_data}; // first byte ends up on top
        end
    end

    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            cnt         <= 4'd0;
            word_valid  <= 1'b0;
            end_pending <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            if (fw_valid) begin
                cnt        <= cnt + 4'd1;
                word_valid <= (cnt == 4'd15);
            end else if (end_pending) begin
                // stream has ended, drop any partial word
                cnt         <= 4'd0;
                end_pending <= 1'b0;
            end
            if (rx_end) begin
                end_pending <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/crc32_check.sv ====
`timescale 1ns/1ps

module crc32_check (
    input  logic       clk_50mhz,
    input  logic       rst,
    input  logic       rx_valid,
    input  logic [1:0] rx_data,
    input  logic       rx_end,
    output logic       crc_ok,
    output logic       crc_bad
);

    logic [31:0] crc;
    logic        in_frame;

    // two line bits per call, rx_data[0] is the earlier one
    function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [1:0] d);
        logic [31:0] r;
        r = c;
        for (int i = 0; i < 2; i++) begin
            r = (r >> 1) ^ ((r[0] ^ d[i]) ? net_pkg::crc_poly : 32'h0);
        end
        return r;
    endfunction

    always_ff @(posedge clk_50mhz) begin
        if (rx_valid) begin
            crc <= crc_step(in_frame ? crc : 32'hffff_ffff, rx_data); // preset on first dibit
        end
    end

    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            in_frame <= 1'b0;
            crc_ok   <= 1'b0;
            crc_bad  <= 1'b0;
        end else begin
            crc_ok  <= 1'b0;
            crc_bad <= 1'b0;
            if (rx_valid) begin
                in_frame <= 1'b1;
            end
            if (rx_end) begin
                in_frame <= 1'b0;
                // fcs included, so a clean frame leaves the residue
                crc_ok   <= (crc == net_pkg::crc_residue);
                crc_bad  <= (crc != net_pkg::crc_residue);
            end
        end
    end

endmodule

// ==== hdl/seven_seg.sv ====
`timescale 1ns/1ps

module seven_seg #(
    parameter integer scan_div = 50_000
) (
    input  logic        clk_50mhz,
    input  logic        rst,
    input  logic [31:0] value,
    output logic [6:0]  seg_cat,
    output logic [7:0]  seg_an
);

    localparam int div_w = (scan_div > 1) ? $clog2(scan_div) : 1;
    localparam logic [div_w-1:0] div_last = div_w'(scan_div - 1);

    logic [div_w-1:0]      div_cnt;
    status_pkg::scan_pos_t pos;
    status_pkg::digit_t    digit;

    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            div_cnt <= '0;
            pos     <= '0;
        end else if (div_cnt == div_last) begin
            div_cnt <= '0;
            pos     <= pos + 3'd1; // next digit
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // digit 0 is the rightmost, low nibble
    assign digit   = value[{pos, 2'b00} +: 4];
    assign seg_cat = status_pkg::seg_table(digit);
    assign seg_an  = ~(8'b0000_0001 << pos); // one anode low

endmodule

// ==== hdl/eth_rx_top.sv ====
`timescale 1ns/1ps

module eth_rx_top #(
    parameter net_pkg::mac_addr_t local_mac = 48'h02_00_00_c0_ff_ee,
    parameter integer scan_div = 50_000
) (
    input  logic        clk_50mhz,
    input  logic        rst,
    input  logic        crsdv,
    input  logic [1:0]  rxd,
    output logic        word_valid,
    output logic [31:0] word,
    output logic        frame_good,
    output logic        frame_bad,
    output logic [15:0] led,
    output logic [6:0]  seg_cat,
    output logic [7:0]  seg_an
);

    logic        rx_valid;
    logic [1:0]  rx_data;
    logic        rx_end;
    logic        bo_valid;
    logic [1:0]  bo_data;
    logic        fw_valid;
    logic [1:0]  fw_data;
    logic        accepted;
    logic        crc_ok;
    logic        crc_bad;
    logic [31:0] disp_word; // last packed word shown on the display

    rmii_rx u_rmii_rx (
        .clk_50mhz(clk_50mhz),
        .rst(rst),
        .crsdv(crsdv),
        .rxd(rxd),
        .rx_valid(rx_valid),
        .rx_data(rx_data),
        .rx_end(rx_end)
    );

    bit_order u_bit_order (
        .clk_50mhz(clk_50mhz),
        .rst(rst),
        .rx_valid(rx_valid),
        .rx_data(rx_data),
        .bo_valid(bo_valid),
        .bo_data(bo_data)
    );

    mac_filter #(.local_mac(local_mac)) u_mac_filter (
        .clk_50mhz(clk_50mhz),
        .rst(rst),
        .bo_valid(bo_valid),
        .bo_data(bo_data),
        .rx_end(rx_end),
        .fw_valid(fw_valid),
        .fw_data(fw_data),
        .accepted(accepted)
    );

    word_pack u_word_pack (
        .clk_50mhz(clk_50mhz),
        .rst(rst),
        .fw_valid(fw_valid),
        .fw_data(fw_data),
        .rx_end(rx_end),
        .word_valid(word_valid),
        .word(word)
    );

    // fcs runs on the raw line order, before reordering
    crc32_check u_crc32_check (
        .clk_50mhz(clk_50mhz),
        .rst(rst),
        .rx_valid(rx_valid),
        .rx_data(rx_data),
        .rx_end(rx_end),
        .crc_ok(crc_ok),
        .crc_bad(crc_bad)
    );

    always_ff @(posedge clk_50mhz) begin
        if (rst) begin
            frame_good <= 1'b0;
            frame_bad  <= 1'b0;
            led        <= 16'd0;
            disp_word  <= 32'd0;
        end else begin
            frame_good <= crc_ok & accepted; // good fcs and our address
            frame_bad  <= crc_bad;
            if (frame_good) begin
                led <= led + 16'd1; // wraps
            end
            if (word_valid) begin
                disp_word <= word;
            end
        end
    end

    seven_seg #(.scan_div(scan_div)) u_seven_seg (
        .clk_50mhz(clk_50mhz),
        .rst(rst),
        .value(disp_word),
        .seg_cat(seg_cat),
        .seg_an(seg_an)
    );

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk_50mhz,
    output logic rst
);

    initial begin
        clk_50mhz = 1'b0;
        forever begin
            #10 clk_50mhz = ~clk_50mhz; // 20 ns period
        end
    end

    // held for two rising edges, released just after the second
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk_50mhz);
        #1;
        rst = 1'b0;
    end

endmodule

// ==== verification/tb_eth_rx.sv ====
`timescale 1ns/1ps

module tb_eth_rx;

    localparam net_pkg::mac_addr_t test_mac  = 48'h02_12_34_56_78_9a;
    localparam net_pkg::mac_addr_t other_mac = 48'h02_12_34_56_78_9b; // one bit off
    localparam net_pkg::mac_addr_t src_mac   = 48'h02_00_00_5e_10_01;
    localparam int scan_div     = 4;
    localparam int done_timeout = 64; // cycles allowed for status and words

    logic        clk_50mhz;
    logic        rst;
    logic        crsdv;
    logic [1:0]  rxd;
    logic        word_valid;
    logic [31:0] word;
    logic        frame_good;
    logic        frame_bad;
    logic [15:0] led;
    logic [6:0]  seg_cat;
    logic [7:0]  seg_an;

    logic [31:0] lfsr = 32'h7188;
    logic [31:0] expect_words [$];
    logic [31:0] shown_word = 32'd0; // word the display should hold
    // active-low hex digit patterns as {g,f,e,d,c,b,a}
    logic [6:0]  seg_ref [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                                  7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};
    int          payload_len [5] = '{16, 8, 12, 20, 8};
    int          error_count = 0;
    int          good_seen = 0;
    int          bad_seen = 0;
    int          good_exp = 0;
    int          bad_exp = 0;
    int unsigned cyc = 0;
    int unsigned last_lit [8];
    int unsigned watchdog_cycles;

    tb_clock u_clock (
        .clk_50mhz(clk_50mhz),
        .rst(rst)
    );

    eth_rx_top #(.local_mac(test_mac), .scan_div(scan_div)) dut (
        .clk_50mhz(clk_50mhz),
        .rst(rst),
        .crsdv(crsdv),
        .rxd(rxd),
        .word_valid(word_valid),
        .word(word),
        .frame_good(frame_good),
        .frame_bad(frame_bad),
        .led(led),
        .seg_cat(seg_cat),
        .seg_an(seg_an)
    );

    // x^32 + x^22 + x^2 + x + 1 with the new bit entering at the bottom
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            b[i] = lfsr[0];
        end
    endtask

    // ethernet crc-32 with bytes going out lsb first
    function automatic logic [31:0] crc_update(input logic [31:0] c, input logic [7:0] b);
        logic [31:0] r;
        r = c;
        for (int i = 0; i < 8; i++) begin
            r = r[0] ^ b[i] ? (r >> 1) ^ 32'hedb8_8320 : r >> 1;
        end
        return r;
    endfunction

    function automatic int frame_dibits(input int payload);
        return (8 + net_pkg::header_bytes + payload + 4) * 4 + 12; // preamble to gap
    endfunction

    function automatic int total_dibits();
        int sum;
        sum = 0;
        foreach (payload_len[i]) begin
            sum += frame_dibits(payload_len[i]);
        end
        return sum;
    endfunction

    function automatic bit frame_settled();
        return good_seen == good_exp && bad_seen == bad_exp && expect_words.size() == 0;
    endfunction

    task automatic drive_dibit(input logic [1:0] d);
        @(posedge clk_50mhz);
        #1;
        crsdv = 1'b1;
        rxd   = d;
    endtask

    task automatic send_byte(input logic [7:0] b);
        for (int i = 0; i < 4; i++) begin
            drive_dibit(b[2*i +: 2]); // low dibit first on the wire
        end
    endtask

    task automatic wait_frame_done();
        int n;
        n = 0;
        while (n < done_timeout && !frame_settled()) begin
            @(posedge clk_50mhz);
            n++;
        end
        if (!frame_settled()) begin
            error_count++;
            $display("frame did not finish: status pulse or words missing after %0d cycles",
                     done_timeout);
        end
    endtask

    task automatic check_counts();
        assert (good_seen == good_exp && bad_seen == bad_exp) else begin
            error_count++;
            $display("ERROR %0t: %0d good and %0d bad pulses, expected %0d and %0d",
                     $time, good_seen, bad_seen, good_exp, bad_exp);
        end
        assert (led == 16'(good_exp)) else begin
            error_count++;
            $display("ERROR %0t: led %0d, expected %0d", $time, led, good_exp);
        end
    endtask

    // flip_bit counts from the first payload bit and a negative value keeps the frame clean
    task automatic run_frame(input net_pkg::mac_addr_t dst, input int payload, input int flip_bit);
        logic [7:0]  fbytes [$];
        logic [7:0]  b;
        logic [31:0] crc;
        logic [31:0] fcs;
        logic        accept;
        logic        crc_good;
        int          n;
        for (int i = 5; i >= 0; i--) begin
            fbytes.push_back(dst[i*8 +: 8]);
        end
        for (int i = 5; i >= 0; i--) begin
            fbytes.push_back(src_mac[i*8 +: 8]);
        end
        fbytes.push_back(8'h88); // local experimental ethertype
        fbytes.push_back(8'hb5);
        for (int i = 0; i < payload; i++) begin
            next_byte(b);
            fbytes.push_back(b);
        end
        crc = 32'hffff_ffff;
        foreach (fbytes[i]) begin
            crc = crc_update(crc, fbytes[i]);
        end
        fcs = ~crc;
        for (int i = 0; i < 4; i++) begin
            fbytes.push_back(fcs[i*8 +: 8]);
        end
        // clean frame with its fcs folds down to the fixed residue
        crc = 32'hffff_ffff;
        foreach (fbytes[i]) begin
            crc = crc_update(crc, fbytes[i]);
        end
        assert (crc == net_pkg::crc_residue) else begin
            error_count++;
            $display("ERROR %0t: crc model gives %h over a clean frame", $time, crc);
        end
        crc_good = (flip_bit < 0);
        if (!crc_good) begin
            n = net_pkg::header_bytes + flip_bit / 8;
            fbytes[n] = fbytes[n] ^ (8'h01 << (flip_bit % 8));
        end
        accept = (dst == test_mac) || (dst == net_pkg::broadcast_mac);
        if (accept) begin
            for (int i = net_pkg::header_bytes; i < fbytes.size(); i += 4) begin
                expect_words.push_back({fbytes[i], fbytes[i+1], fbytes[i+2], fbytes[i+3]});
            end
        end
        if (accept && crc_good) begin
            good_exp++;
        end
        if (!crc_good) begin
            bad_exp++;
        end
        for (int i = 0; i < 7; i++) begin
            send_byte(8'h55);
        end
        send_byte(8'hd5);
        foreach (fbytes[i]) begin
            send_byte(fbytes[i]);
        end
        @(posedge clk_50mhz);
        #1;
        crsdv = 1'b0;
        rxd   = 2'b00;
        wait_frame_done();
        repeat (12) @(posedge clk_50mhz); // interframe gap
        check_counts();
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk_50mhz) begin
        if (!rst) begin
            if (frame_good) begin
                good_seen++;
            end
            if (frame_bad) begin
                bad_seen++;
            end
            // display latch loads one cycle after word_valid
            for (int i = 0; i < 8; i++) begin
                if (!seg_an[i]) begin
                    assert (seg_cat == seg_ref[shown_word[i*4 +: 4]]) else begin
                        error_count++;
                        $display("ERROR %0t: digit %0d segments %b, expected %b",
                                 $time, i, seg_cat, seg_ref[shown_word[i*4 +: 4]]);
                    end
                end
            end
            if (word_valid && expect_words.size() == 0) begin
                error_count++;
                $display("word_valid at %0t with no word expected, word %h", $time, word);
            end else if (word_valid) begin
                assert (word == expect_words[0]) else begin
                    error_count++;
                    $display("ERROR %0t: word %h, expected %h", $time, word, expect_words[0]);
                end
                shown_word = expect_words[0];
                void'(expect_words.pop_front());
            end
        end
    end

    // every digit comes round within one full scan
    always @(negedge clk_50mhz) begin
        if (rst) begin
            cyc = 0;
            for (int i = 0; i < 8; i++) begin
                last_lit[i] = 0;
            end
        end else begin
            cyc++;
            for (int i = 0; i < 8; i++) begin
                if (!seg_an[i]) begin
                    last_lit[i] = cyc;
                end
                assert (cyc - last_lit[i] <= 8 * scan_div) else begin
                    error_count++;
                    $display("ERROR %0t: digit %0d not selected for %0d cycles",
                             $time, i, cyc - last_lit[i]);
                end
            end
        end
    end

    assert property (@(posedge clk_50mhz) disable iff (rst) $onehot(~seg_an)) else begin
        error_count++;
        $display("ERROR %0t: seg_an %b does not select exactly one digit", $time, seg_an);
    end

    assert property (@(posedge clk_50mhz) disable iff (rst) !(frame_good && frame_bad)) else begin
        error_count++;
        $display("ERROR %0t: frame_good and frame_bad high together", $time);
    end

    initial begin
        watchdog_cycles = 200 * total_dibits() + 500;
        repeat (watchdog_cycles) @(posedge clk_50mhz);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        crsdv = 1'b0;
        rxd   = 2'b00;
        wait (rst === 1'b0);
        @(negedge clk_50mhz);
        assert (!word_valid && !frame_good && !frame_bad && led == 16'd0 && $onehot(~seg_an))
        else begin
            error_count++;
            $display("ERROR %0t: outputs not at reset values, led %0d seg_an %b",
                     $time, led, seg_an);
        end
        run_frame(test_mac, payload_len[0], -1);
        run_frame(net_pkg::broadcast_mac, payload_len[1], -1);
        run_frame(other_mac, payload_len[2], -1); // filtered out
        run_frame(test_mac, payload_len[3], 37);  // one payload bit corrupted
        run_frame(test_mac, payload_len[4], -1);  // recovery after a bad fcs
        $display("errors: %0d  good frames: %0d  bad frames: %0d  led: %0d",
                 error_count, good_seen, bad_seen, led);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/net_pkg.sv
hdl/status_pkg.sv
hdl/rmii_rx.sv
hdl/bit_order.sv
hdl/mac_filter.sv
hdl/word_pack.sv
hdl/crc32_check.sv
hdl/seven_seg.sv
hdl/eth_rx_top.sv
verification/tb_clock.sv
verification/tb_eth_rx.sv

// ==== Bender.yml ====
package:
  name: eth_rx

sources:
  - files:
      - hdl/net_pkg.sv
      - hdl/status_pkg.sv
      - hdl/rmii_rx.sv
      - hdl/bit_order.sv
      - hdl/mac_filter.sv
      - hdl/word_pack.sv
      - hdl/crc32_check.sv
      - hdl/seven_seg.sv
      - hdl/eth_rx_top.sv
  - target: simulation
    files:
      - verification/tb_clock.sv
      - verification/tb_eth_rx.sv
